/* verilog/ptw_pkg.sv */
package ptw_pkg;

    // Sv39 address geometry
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned VLEN    = 39;
    localparam int unsigned PLEN    = 56;
    localparam int unsigned VPN_W   = 27;
    localparam int unsigned PSCID_W = 20;
    localparam int unsigned CAUSE_W = 8;

    // Fault cause codes reported with fault_o
    localparam logic [CAUSE_W-1:0] CAUSE_LD_ACCESS = 8'd5;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_ACCESS = 8'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_LD_PAGE   = 8'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_PAGE   = 8'd15;

    // Sv39 page-table entry, MSB first
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } lvl_e;

    // IOTLB miss request
    typedef struct packed {
        logic [VLEN-1:0]    iova;
        logic [PSCID_W-1:0] pscid;
        logic               is_store;
    } ptw_req_t;

    // Entry written into the IOTLB at the end of a good walk
    typedef struct packed {
        logic [VPN_W-1:0]   vpn;
        logic [PPN_W-1:0]   ppn;
        logic               is_2m;
        logic               is_1g;
        logic               g;
        logic [PSCID_W-1:0] pscid;
    } tlb_update_t;

    // Wishbone master to slave
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [PLEN-1:0] adr;
        logic [7:0]      sel;
    } wb_req_t;

    // Wishbone slave to master
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [63:0] dat;
    } wb_rsp_t;

    // PTE checker result for the current level
    typedef struct packed {
        logic               fault;
        logic               leaf;
        logic [CAUSE_W-1:0] cause;
    } pte_verdict_t;

endpackage

/* verilog/ptw_wb_master.sv */
`timescale 1ns/1ps

module ptw_wb_master (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          fetch_req_i,
    input  logic [ptw_pkg::PLEN-1:0]      fetch_adr_i,
    input  ptw_pkg::wb_rsp_t              wb_i,
    output ptw_pkg::wb_req_t              wb_o,
    output logic                          rsp_valid_o,
    output logic                          rsp_err_o,
    output ptw_pkg::pte_t                 rsp_pte_o
);
    import ptw_pkg::*;

    // Cycle in flight, cyc and stb move together
    logic            cyc_q;
    logic [PLEN-1:0] adr_q;
    logic            rsp_valid_q;
    logic            rsp_err_q;
    logic [63:0]     rsp_dat_q;
    logic            done;

    // Slave ends the cycle with either ack or err
    assign done = cyc_q && (wb_i.ack || wb_i.err);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= done;
            if (done) begin
                cyc_q <= 1'b0;
            end else if (fetch_req_i) begin
                cyc_q <= 1'b1;
            end
        end
    end

    // Address held stable for the whole cycle, data captured on the ending edge
    always_ff @(posedge clk_i) begin
        if (fetch_req_i && !cyc_q) begin
            adr_q <= fetch_adr_i;
        end
        if (done) begin
            rsp_dat_q <= wb_i.dat;
            rsp_err_q <= wb_i.err;
        end
    end

    // Read only, full 64-bit lane
    assign wb_o.cyc = cyc_q;
    assign wb_o.stb = cyc_q;
    assign wb_o.we  = 1'b0;
    assign wb_o.adr = adr_q;
    assign wb_o.sel = 8'hff;

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_err_o   = rsp_err_q;
    assign rsp_pte_o   = pte_t'(rsp_dat_q);

endmodule

/* verilog/ptw_pte_check.sv */
`timescale 1ns/1ps

module ptw_pte_check (
    input  ptw_pkg::pte_t         pte_i,
    input  ptw_pkg::lvl_e         lvl_i,
    input  logic                  is_store_i,
    output ptw_pkg::pte_verdict_t verdict_o
);
    import ptw_pkg::*;

    logic               is_leaf;
    logic               misaligned;
    logic [CAUSE_W-1:0] page_cause;

    // R or X set marks a leaf, otherwise a pointer to the next table
    assign is_leaf = pte_i.r || pte_i.x;

    // Superpage PPN must be aligned to its size
    always_comb begin
        case (lvl_i)
            LVL1:    misaligned = (pte_i.ppn[17:0] != '0);
            LVL2:    misaligned = (pte_i.ppn[8:0] != '0);
            default: misaligned = 1'b0;
        endcase
    end

    // Every rule here raises a page fault of the original access type
    assign page_cause = is_store_i ? CAUSE_ST_PAGE : CAUSE_LD_PAGE;

    always_comb begin
        verdict_o.fault = 1'b0;
        verdict_o.leaf  = 1'b0;
        verdict_o.cause = '0;
        // Not valid, or the reserved W without R encoding
        if (!pte_i.v || (!pte_i.r && pte_i.w)) begin
            verdict_o.fault = 1'b1;
        // Bits 63:54 must be zero, no Svnapot or Svpbmt here
        end else if (pte_i.reserved != '0) begin
            verdict_o.fault = 1'b1;
        end else if (is_leaf) begin
            // Misaligned superpage
            if (misaligned) begin
                verdict_o.fault = 1'b1;
            // No hardware A/D update, software must have set them
            end else if (!pte_i.a || (is_store_i && !pte_i.d)) begin
                verdict_o.fault = 1'b1;
            end else begin
                verdict_o.leaf = 1'b1;
            end
        end else begin
            // D, A and U are reserved in a pointer
            if (pte_i.d || pte_i.a || pte_i.u) begin
                verdict_o.fault = 1'b1;
            // Pointer found in the last table, walk would run off the end
            end else if (lvl_i == LVL3) begin
                verdict_o.fault = 1'b1;
            end
        end
        if (verdict_o.fault) begin
            verdict_o.cause = page_cause;
        end
    end

endmodule

/* verilog/ptw_walk_ctrl.sv */
`timescale 1ns/1ps

module ptw_walk_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         miss_i,
    input  ptw_pkg::ptw_req_t            req_i,
    input  logic [ptw_pkg::PPN_W-1:0]    iosatp_ppn_i,
    input  logic                         dtf_i,
    input  logic                         rsp_valid_i,
    input  logic                         rsp_err_i,
    input  ptw_pkg::pte_t                rsp_pte_i,
    input  ptw_pkg::pte_verdict_t        verdict_i,
    output logic                         fetch_req_o,
    output logic [ptw_pkg::PLEN-1:0]     fetch_adr_o,
    output ptw_pkg::lvl_e                lvl_o,
    output logic                         is_store_o,
    output logic                         busy_o,
    output logic                         update_o,
    output ptw_pkg::tlb_update_t         update_data_o,
    output logic                         fault_o,
    output logic [ptw_pkg::CAUSE_W-1:0]  cause_o
);
    import ptw_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        REPORT
    } state_e;

    state_e             state_q, state_d;
    lvl_e               lvl_q, lvl_next;
    ptw_req_t           req_q;
    logic [PLEN-1:0]    pptr_q;
    logic               start_q;
    logic               g_acc_q;
    logic               update_q;
    logic               fault_q;
    tlb_update_t        update_data_q;
    logic [CAUSE_W-1:0] cause_q;
    logic [8:0]         vpn_next;
    logic [PLEN-1:0]    next_ptr;
    logic               miss_take;
    logic               rsp_done;
    logic               ptr_step;
    logic               leaf_evt;
    logic               fault_evt;

    // New miss only accepted when no walk is running
    assign miss_take = miss_i && (state_q != WALK);
    assign rsp_done  = (state_q == WALK) && rsp_valid_i;

    // Bus error wins over whatever the checker saw in the data
    assign fault_evt = rsp_done && (rsp_err_i || verdict_i.fault);
    assign leaf_evt  = rsp_done && !rsp_err_i && !verdict_i.fault && verdict_i.leaf;
    assign ptr_step  = rsp_done && !rsp_err_i && !verdict_i.fault && !verdict_i.leaf;

    // Index into the next table, VPN[1] after the root, VPN[0] after that
    always_comb begin
        if (lvl_q == LVL1) begin
            vpn_next = req_q.iova[29:21];
            lvl_next = LVL2;
        end else begin
            vpn_next = req_q.iova[20:12];
            lvl_next = LVL3;
        end
    end

    assign next_ptr = {rsp_pte_i.ppn, vpn_next, 3'b000};

    // First fetch comes from the registered root pointer, later ones straight off the PTE
    assign fetch_req_o = start_q || ptr_step;
    assign fetch_adr_o = start_q ? pptr_q : next_ptr;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, REPORT: state_d = miss_take ? WALK : IDLE;
            WALK:         state_d = (rsp_done && !ptr_step) ? REPORT : WALK;
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            lvl_q    <= LVL1;
            start_q  <= 1'b0;
            g_acc_q  <= 1'b0;
            update_q <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            state_q  <= state_d;
            start_q  <= miss_take;
            update_q <= leaf_evt;
            // DTF keeps the fault from being reported, the walk still ends
            fault_q  <= fault_evt && !dtf_i;
            if (miss_take) begin
                lvl_q   <= LVL1;
                g_acc_q <= 1'b0;
            end else if (ptr_step) begin
                lvl_q   <= lvl_next;
                g_acc_q <= g_acc_q || rsp_pte_i.g;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_take) begin
            req_q  <= req_i;
            // Root table entry selected by VPN[2]
            pptr_q <= {iosatp_ppn_i, req_i.iova[38:30], 3'b000};
        end
        if (leaf_evt) begin
            update_data_q.vpn   <= req_q.iova[38:12];
            update_data_q.ppn   <= rsp_pte_i.ppn;
            update_data_q.is_2m <= (lvl_q == LVL2);
            update_data_q.is_1g <= (lvl_q == LVL1);
            update_data_q.g     <= g_acc_q || rsp_pte_i.g;
            update_data_q.pscid <= req_q.pscid;
        end
        if (fault_evt) begin
            if (rsp_err_i) begin
                cause_q <= req_q.is_store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
            end else begin
                cause_q <= verdict_i.cause;
            end
        end
    end

    assign lvl_o         = lvl_q;
    assign is_store_o    = req_q.is_store;
    assign busy_o        = (state_q == WALK);
    assign update_o      = update_q;
    assign update_data_o = update_data_q;
    assign fault_o       = fault_q;
    assign cause_o       = cause_q;

endmodule

/* verilog/iommu_ptw_top.sv */
`timescale 1ns/1ps

module iommu_ptw_top (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         miss_i,
    input  ptw_pkg::ptw_req_t            req_i,
    input  logic [ptw_pkg::PPN_W-1:0]    iosatp_ppn_i,
    input  logic                         dtf_i,
    input  ptw_pkg::wb_rsp_t             wb_i,
    output ptw_pkg::wb_req_t             wb_o,
    output logic                         busy_o,
    output logic                         update_o,
    output ptw_pkg::tlb_update_t         update_data_o,
    output logic                         fault_o,
    output logic [ptw_pkg::CAUSE_W-1:0]  cause_o
);
    import ptw_pkg::*;

    // Control to bus stage
    logic            fetch_req;
    logic [PLEN-1:0] fetch_adr;
    // Bus stage back to control and check
    logic            rsp_valid;
    logic            rsp_err;
    pte_t            rsp_pte;
    // Check stage result and its context
    pte_verdict_t    verdict;
    lvl_e            lvl;
    logic            is_store;

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (miss_i),
        .req_i         (req_i),
        .iosatp_ppn_i  (iosatp_ppn_i),
        .dtf_i         (dtf_i),
        .rsp_valid_i   (rsp_valid),
        .rsp_err_i     (rsp_err),
        .rsp_pte_i     (rsp_pte),
        .verdict_i     (verdict),
        .fetch_req_o   (fetch_req),
        .fetch_adr_o   (fetch_adr),
        .lvl_o         (lvl),
        .is_store_o    (is_store),
        .busy_o        (busy_o),
        .update_o      (update_o),
        .update_data_o (update_data_o),
        .fault_o       (fault_o),
        .cause_o       (cause_o)
    );

    ptw_wb_master u_wb_master (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .fetch_req_i (fetch_req),
        .fetch_adr_i (fetch_adr),
        .wb_i        (wb_i),
        .wb_o        (wb_o),
        .rsp_valid_o (rsp_valid),
        .rsp_err_o   (rsp_err),
        .rsp_pte_o   (rsp_pte)
    );

    ptw_pte_check u_pte_check (
        .pte_i      (rsp_pte),
        .lvl_i      (lvl),
        .is_store_i (is_store),
        .verdict_o  (verdict)
    );

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    // 8 ns clock period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held low over the first 2 rising edges
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

/* sim/ptw_props.sv */
`timescale 1ns/1ps

module ptw_props (
    input logic             clk_i,
    input logic             rst_ni,
    input ptw_pkg::wb_req_t wb_req_i,
    input ptw_pkg::wb_rsp_t wb_rsp_i,
    input logic             update_i,
    input logic             fault_i
);
    // Failed properties, read by the testbench at the end
    int prop_errors = 0;

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_req_i.stb |-> wb_req_i.cyc)
        else begin
            prop_errors++;
            $error("Wishbone stb high while cyc is low");
        end

    // Address held until the slave ends the cycle
    adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_req_i.stb && !wb_rsp_i.ack && !wb_rsp_i.err) |=> $stable(wb_req_i.adr))
        else begin
            prop_errors++;
            $error("Wishbone address changed before ack or err");
        end

    // A walk ends in exactly one kind of result
    one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_i && fault_i))
        else begin
            prop_errors++;
            $error("update and fault high in the same cycle");
        end

endmodule

bind iommu_ptw_top ptw_props u_props (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_o),
    .wb_rsp_i (wb_i),
    .update_i (update_o),
    .fault_i  (fault_o)
);

/* sim/tb_ptw.sv */
`timescale 1ns/1ps

module tb_ptw;
    import ptw_pkg::*;

    // Limit well above 15 walks x 3 fetches x at most 8 cycles (360)
    localparam int MAX_CYCLES = 2000;

    // Page tables at fixed frames
    localparam logic [PPN_W-1:0] ROOT_PPN = 44'h00100;
    localparam logic [PPN_W-1:0] T2_PPN   = 44'h00200;
    localparam logic [PPN_W-1:0] T3_PPN   = 44'h00300;

    // PTE flag bits in {d, a, g, u, x, w, r, v} order
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_G = 8'h20;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic               clk_i;
    logic               rst_ni;
    logic               miss = 1'b0;
    ptw_req_t           req = '0;
    logic [PPN_W-1:0]   root_ppn = '0;
    logic               dtf = 1'b0;
    wb_rsp_t            wb_rsp = '0;
    wb_req_t            wb_req;
    logic               busy;
    logic               upd;
    tlb_update_t        upd_data;
    logic               fault;
    logic [CAUSE_W-1:0] cause;

    // Walk results seen by run_walk
    int                 saw_update;
    int                 saw_fault;
    int                 walk_cycles;
    tlb_update_t        got_upd;
    logic [CAUSE_W-1:0] got_cause;
    int                 errors = 0;
    int                 cycle_count = 0;

    // Slave memory and the addresses that answer with err
    logic [63:0] mem [logic [PLEN-1:0]];
    bit          err_adr [logic [PLEN-1:0]];
    int          ack_wait = 0;
    bit          pending = 1'b0;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    iommu_ptw_top UUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (miss),
        .req_i         (req),
        .iosatp_ppn_i  (root_ppn),
        .dtf_i         (dtf),
        .wb_i          (wb_rsp),
        .wb_o          (wb_req),
        .busy_o        (busy),
        .update_o      (upd),
        .update_data_o (upd_data),
        .fault_o       (fault),
        .cause_o       (cause)
    );

    // Wishbone slave answering 0 to 3 cycles after the strobe
    initial begin
        void'($urandom(32'h1c0d));
        forever begin
            @(posedge clk_i);
            #1;
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack && !wb_rsp.err) begin
                expect_true(!wb_req.we, "Wishbone we high during a PTE read");
                expect_true(wb_req.sel == 8'hff,
                            $sformatf("Wishbone sel %h, expected ff", wb_req.sel));
                if (!pending) begin
                    pending  = 1'b1;
                    ack_wait = int'($urandom % 4);
                end
                if (ack_wait == 0) begin
                    pending = 1'b0;
                    if (err_adr.exists(wb_req.adr)) begin
                        wb_rsp.err = 1'b1;
                    end else begin
                        wb_rsp.ack = 1'b1;
                        // Unwritten entries read as zero and so as an invalid PTE
                        wb_rsp.dat = mem.exists(wb_req.adr) ? mem[wb_req.adr] : 64'h0;
                    end
                end else begin
                    ack_wait--;
                end
            end else begin
                wb_rsp = '0;
            end
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [63:0] make_pte(input logic [PPN_W-1:0] ppn, input logic [7:0] flags);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // Sv39 entry address is the table base plus 8 bytes per VPN index
    function automatic logic [PLEN-1:0] table_addr(input logic [PPN_W-1:0] ppn,
                                                   input logic [8:0] idx);
        return {ppn, idx, 3'b000};
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        assert (cond) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    // Fresh tables along the path of one IOVA
    task automatic build_tables(input logic [VLEN-1:0] iova, input logic [63:0] pte1,
                                input logic [63:0] pte2, input logic [63:0] pte3);
        mem.delete();
        err_adr.delete();
        mem[table_addr(ROOT_PPN, iova[38:30])] = pte1;
        mem[table_addr(T2_PPN, iova[29:21])]   = pte2;
        mem[table_addr(T3_PPN, iova[20:12])]   = pte3;
    endtask

    // One miss and then watch until busy drops
    task automatic run_walk(input logic [VLEN-1:0] iova, input logic [PSCID_W-1:0] pscid,
                            input logic is_store, input logic use_dtf);
        @(posedge clk_i);
        #1;
        req.iova     = iova;
        req.pscid    = pscid;
        req.is_store = is_store;
        miss         = 1'b1;
        dtf          = use_dtf;
        saw_update   = 0;
        saw_fault    = 0;
        walk_cycles  = 0;
        @(posedge clk_i);
        #1;
        miss = 1'b0;
        do begin
            @(negedge clk_i);
            if (busy) begin
                walk_cycles++;
            end
            if (upd) begin
                saw_update++;
                got_upd = upd_data;
            end
            if (fault) begin
                saw_fault++;
                got_cause = cause;
            end
        end while (busy);
        @(posedge clk_i);
        #1;
        // A result still high one cycle later counts as an extra result
        if (upd) begin
            saw_update++;
        end
        if (fault) begin
            saw_fault++;
        end
        dtf = 1'b0;
    endtask

    task automatic expect_update(input string name, input logic [VLEN-1:0] iova,
                                 input logic [PSCID_W-1:0] pscid, input logic [PPN_W-1:0] ppn,
                                 input logic is_2m, input logic is_1g, input logic g);
        expect_true(saw_update == 1, $sformatf("%s: %0d updates, expected 1", name, saw_update));
        expect_true(saw_fault == 0, $sformatf("%s: unexpected fault", name));
        expect_true(got_upd.vpn == iova[38:12], $sformatf("%s: vpn %h", name, got_upd.vpn));
        expect_true(got_upd.ppn == ppn, $sformatf("%s: ppn %h", name, got_upd.ppn));
        expect_true(got_upd.pscid == pscid, $sformatf("%s: pscid %h", name, got_upd.pscid));
        expect_true(got_upd.is_2m == is_2m, $sformatf("%s: is_2m %b", name, got_upd.is_2m));
        expect_true(got_upd.is_1g == is_1g, $sformatf("%s: is_1g %b", name, got_upd.is_1g));
        expect_true(got_upd.g == g, $sformatf("%s: global %b", name, got_upd.g));
    endtask

    task automatic expect_fault(input string name, input logic [CAUSE_W-1:0] exp_cause);
        expect_true(saw_fault == 1, $sformatf("%s: %0d faults, expected 1", name, saw_fault));
        expect_true(saw_update == 0, $sformatf("%s: unexpected update", name));
        expect_true(got_cause == exp_cause,
                    $sformatf("%s: cause %0d, expected %0d", name, got_cause, exp_cause));
    endtask

    task automatic four_k_walk();
        logic [VLEN-1:0] iova;
        iova = 39'h15_5A5A_5123;
        // G on the middle pointer reaches the update
        build_tables(iova, make_pte(T2_PPN, F_V), make_pte(T3_PPN, F_V | F_G),
                     make_pte(44'hABCDE, F_V | F_R | F_A | F_D));
        run_walk(iova, 20'h01234, 1'b0, 1'b0);
        expect_update("4K walk with G", iova, 20'h01234, 44'hABCDE, 1'b0, 1'b0, 1'b1);
        build_tables(iova, make_pte(T2_PPN, F_V), make_pte(T3_PPN, F_V),
                     make_pte(44'h13579, F_V | F_R | F_W | F_A | F_D));
        run_walk(iova, 20'h0BEEF, 1'b1, 1'b0);
        expect_update("4K store walk", iova, 20'h0BEEF, 44'h13579, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic superpage_walks();
        logic [VLEN-1:0] iova;
        iova = 39'h2A_1234_5000;
        build_tables(iova, make_pte(44'h00C_0000, F_V | F_R | F_X | F_A | F_G), 64'h0, 64'h0);
        run_walk(iova, 20'h00011, 1'b0, 1'b0);
        expect_update("1G leaf", iova, 20'h00011, 44'h00C_0000, 1'b0, 1'b1, 1'b1);
        build_tables(iova, make_pte(T2_PPN, F_V),
                     make_pte(44'h3_4600, F_V | F_R | F_W | F_A | F_D), 64'h0);
        run_walk(iova, 20'h00022, 1'b1, 1'b0);
        expect_update("2M leaf", iova, 20'h00022, 44'h3_4600, 1'b1, 1'b0, 1'b0);
        // PPN[8:0] nonzero at LVL2
        build_tables(iova, make_pte(T2_PPN, F_V),
                     make_pte(44'h3_4601, F_V | F_R | F_W | F_A | F_D), 64'h0);
        run_walk(iova, 20'h00033, 1'b0, 1'b0);
        expect_fault("misaligned 2M load", 8'd13);
        run_walk(iova, 20'h00033, 1'b1, 1'b0);
        expect_fault("misaligned 2M store", 8'd15);
    endtask

    task automatic pte_rule_faults();
        logic [VLEN-1:0] iova;
        logic [63:0]     ptr2;
        logic [63:0]     ptr3;
        iova = 39'h0F_0F0F_0000;
        ptr2 = make_pte(T2_PPN, F_V);
        ptr3 = make_pte(T3_PPN, F_V);
        build_tables(iova, make_pte(T2_PPN, F_R | F_A), 64'h0, 64'h0);
        run_walk(iova, 20'h00100, 1'b0, 1'b0);
        expect_fault("v clear", 8'd13);
        build_tables(iova, ptr2, make_pte(44'h00500, F_V | F_W | F_A | F_D), 64'h0);
        run_walk(iova, 20'h00101, 1'b1, 1'b0);
        expect_fault("W without R", 8'd15);
        build_tables(iova, ptr2, ptr3, make_pte(44'h00777, F_V | F_R | F_W | F_A));
        run_walk(iova, 20'h00102, 1'b1, 1'b0);
        expect_fault("store with D clear", 8'd15);
        build_tables(iova, make_pte(T2_PPN, F_V | F_A), 64'h0, 64'h0);
        run_walk(iova, 20'h00103, 1'b0, 1'b0);
        expect_fault("pointer with A", 8'd13);
        build_tables(iova, ptr2, ptr3, make_pte(44'h00888, F_V));
        run_walk(iova, 20'h00104, 1'b0, 1'b0);
        expect_fault("pointer at LVL3", 8'd13);
    endtask

    task automatic bus_error_fault();
        logic [VLEN-1:0] iova;
        iova = 39'h33_0000_1000;
        build_tables(iova, make_pte(T2_PPN, F_V), make_pte(T3_PPN, F_V),
                     make_pte(44'h00999, F_V | F_R | F_A | F_D));
        // Second fetch hits a bad address
        err_adr[table_addr(T2_PPN, iova[29:21])] = 1'b1;
        run_walk(iova, 20'h00200, 1'b0, 1'b0);
        expect_fault("bus error load", 8'd5);
        run_walk(iova, 20'h00201, 1'b1, 1'b0);
        expect_fault("bus error store", 8'd7);
    endtask

    task automatic dtf_suppression();
        logic [VLEN-1:0] iova;
        iova = 39'h01_2345_6000;
        build_tables(iova, make_pte(T2_PPN, F_R | F_A), 64'h0, 64'h0);
        run_walk(iova, 20'h00300, 1'b0, 1'b1);
        expect_true(walk_cycles > 0, "DTF walk never raised busy");
        expect_true(saw_fault == 0, "DTF walk reported a fault");
        expect_true(saw_update == 0, "DTF walk reported an update");
        // Next clean walk is unaffected
        build_tables(iova, make_pte(T2_PPN, F_V), make_pte(T3_PPN, F_V),
                     make_pte(44'h00AAA, F_V | F_R | F_A));
        run_walk(iova, 20'h00301, 1'b0, 1'b0);
        expect_update("walk after DTF", iova, 20'h00301, 44'h00AAA, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        root_ppn = ROOT_PPN;
        @(posedge rst_ni);
        expect_true(!busy && !upd && !fault && !wb_req.cyc && !wb_req.stb,
                    "outputs not idle after reset");
        four_k_walk();
        superpage_walks();
        pte_rule_faults();
        bus_error_fault();
        dtf_suppression();
        $display("Closing: %0d check errors, %0d property errors",
                 errors, UUT.u_props.prop_errors);
        if (errors == 0 && UUT.u_props.prop_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/ptw_pkg.sv
verilog/ptw_wb_master.sv
verilog/ptw_pte_check.sv
verilog/ptw_walk_ctrl.sv
verilog/iommu_ptw_top.sv
sim/tb_clk_gen.sv
sim/ptw_props.sv
sim/tb_ptw.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ptw
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
